// File: Bender.yml
package:
  name: tetris_input

sources:
  - include_dirs:
      - logic
    files:
      - logic/tetris_pkg.sv
      - logic/uart_rx.sv
      - logic/debouncer.sv
      - logic/game_control.sv
      - logic/piece_engine.sv
      - logic/tetris_input_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/tb_tetris_input.sv

// File: dv/tb_tetris_input.sv
`default_nettype none

`include "tetris_defines.svh"

module tb_tetris_input;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int BIT_TIME     = `CLKS_PER_BIT;
  localparam int IDLE_TIMEOUT = 2000;

  logic                    clk;
  logic                    reset_n;
  logic [3:0]              usr_btn;
  logic [3:0]              usr_sw;
  logic                    uart_rx;
  logic                    start;
  logic                    over;
  logic [5:0]              count_down;
  tetris_pkg::game_state_t game_state;
  logic [3:0]              piece_col;
  logic [4:0]              piece_row;
  logic [1:0]              piece_rot;
  logic                    held;
  logic [3:0]              score;

  // Expected piece state
  int   m_col;
  int   m_rot;
  logic m_held;
  int   m_score;
  int   error_count;

  tetris_input_top u_dut (
    .clk       (clk),
    .reset_n   (reset_n),
    .usr_btn   (usr_btn),
    .usr_sw    (usr_sw),
    .uart_rx   (uart_rx),
    .start     (start),
    .over      (over),
    .count_down(count_down),
    .game_state(game_state),
    .piece_col (piece_col),
    .piece_row (piece_row),
    .piece_rot (piece_rot),
    .held      (held),
    .score     (score)
  );

  always #10 clk = ~clk;

  // Inputs change and outputs are sampled 2 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic stop_run(input string why);
    error_count++;
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      stop_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_model();
    check_val("piece_col", piece_col, m_col);
    check_val("piece_rot", piece_rot, m_rot);
    check_val("held", held, m_held);
    check_val("score", score, m_score);
  endtask

  function automatic int clamp_col(input int col);
    if (col < 0) begin
      return 0;
    end
    if (col > `BOARD_COLS - 1) begin
      return `BOARD_COLS - 1;
    end
    return col;
  endfunction

  // 8N1, LSB first, with one extra idle bit after the stop bit
  task automatic send_byte(input logic [7:0] data);
    uart_rx = 1'b0;
    repeat (BIT_TIME) next_cycle();
    for (int i = 0; i < 8; i++) begin
      uart_rx = data[i];
      repeat (BIT_TIME) next_cycle();
    end
    uart_rx = 1'b1;
    repeat (2 * BIT_TIME) next_cycle();
  endtask

  task automatic press_btn(input int idx);
    usr_btn[idx] = 1'b1;
    repeat (2 * `DEBOUNCE_CYCLES) next_cycle();
    usr_btn[idx] = 1'b0;
    // Release has to pass the debouncer too
    repeat (2 * `DEBOUNCE_CYCLES) next_cycle();
  endtask

  task automatic flip_sw(input int idx);
    usr_sw[idx] = ~usr_sw[idx];
    repeat (`DEBOUNCE_CYCLES) next_cycle();
  endtask

  // A state counts once it holds longer than the gap between queued commands
  task automatic wait_state(input tetris_pkg::game_state_t want, input int limit);
    int stable;
    int waited;
    stable = 0;
    waited = 0;
    while (stable < `MOVE_CYCLES + 2) begin
      next_cycle();
      waited++;
      if (game_state == want) begin
        stable++;
      end else begin
        stable = 0;
      end
      if (waited > limit) begin
        stop_run($sformatf("timeout waiting for game_state %s", want.name()));
      end
    end
  endtask

  task automatic wait_idle();
    wait_state(tetris_pkg::WAIT, IDLE_TIMEOUT);
  endtask

  task automatic send_move(input logic [7:0] key, input int dcol, input int drot);
    send_byte(key);
    m_col = clamp_col(m_col + dcol);
    m_rot = (m_rot + drot + 4) % 4;
  endtask

  task automatic test_reset_state();
    check_val("start", start, 0);
    check_val("over", over, 0);
    check_val("game_state", game_state, tetris_pkg::IDLE);
    check_val("count_down", count_down, `COUNT_SEC);
    press_btn(0);
    wait_idle();
    check_val("start", start, 1);
    m_col   = `SPAWN_COL;
    m_rot   = 0;
    m_held  = 1'b0;
    m_score = 0;
    check_model();
    check_val("piece_row", piece_row, 0);
  endtask

  task automatic test_moves();
    send_move("a", -1, 0);
    wait_idle();
    check_model();
    send_move("D", 1, 0);
    wait_idle();
    check_model();
    // Arrow right
    send_byte(8'h1B);
    send_byte("[");
    send_move("C", 1, 0);
    wait_idle();
    check_model();
    for (int i = 0; i < 12; i++) begin
      send_move("a", -1, 0);
    end
    wait_idle();
    check_model();
    check_val("piece_col", piece_col, 0);
    send_move("x", 0, 1);
    send_move("x", 0, 1);
    send_move("z", 0, -1);
    wait_idle();
    check_model();
  endtask

  task automatic test_queueing();
    int pick;
    int lo;
    int hi;
    for (int i = 0; i < `QSIZE; i++) begin
      pick = $urandom % 2;
      if (pick == 1) begin
        send_move("d", 1, 0);
      end else begin
        send_move("a", -1, 0);
      end
    end
    wait_idle();
    check_model();
    // Oversized burst, only the reachable column range is known
    lo = m_col;
    hi = m_col;
    for (int i = 0; i < 2 * `QSIZE; i++) begin
      pick = $urandom % 2;
      if (pick == 1) begin
        send_byte("d");
        hi = clamp_col(hi + 1);
      end else begin
        send_byte("a");
        lo = clamp_col(lo - 1);
      end
    end
    wait_idle();
    assert (piece_col >= lo && piece_col <= hi) else begin
      stop_run($sformatf("mismatch piece_col: got 0x%0h, expected 0x%0h to 0x%0h",
                         piece_col, lo, hi));
    end
  endtask

  task automatic test_switches_buttons();
    flip_sw(2);
    m_rot = (m_rot + 3) % 4;
    wait_idle();
    check_val("piece_rot", piece_rot, m_rot);
    // Hold respawns the piece
    flip_sw(1);
    m_held = ~m_held;
    m_col  = `SPAWN_COL;
    m_rot  = 0;
    wait_idle();
    check_model();
    press_btn(2);
    m_rot = (m_rot + 1) % 4;
    wait_idle();
    check_model();
  endtask

  task automatic test_locking();
    send_move("a", -1, 0);
    wait_idle();
    check_model();
    for (int i = 0; i < `MAX_PIECES; i++) begin
      send_byte("w");
      m_score++;
      m_col = `SPAWN_COL;
      m_rot = 0;
      if (m_score < `MAX_PIECES) begin
        wait_idle();
      end else begin
        wait_state(tetris_pkg::END, IDLE_TIMEOUT);
      end
      check_model();
    end
    check_val("over", over, 1);
    repeat (`OVER_TICK) next_cycle();
    press_btn(0);
    wait_state(tetris_pkg::IDLE, IDLE_TIMEOUT);
    check_val("start", start, 0);
    check_val("over", over, 0);
  endtask

  // Switch 0 toggled every cycle pushes drops faster than the engine takes them
  task automatic test_overflow();
    press_btn(0);
    wait_idle();
    m_col   = `SPAWN_COL;
    m_rot   = 0;
    m_held  = 1'b0;
    m_score = 0;
    check_model();
    check_val("piece_row", piece_row, 0);
    for (int i = 0; i < 2 * `QSIZE; i++) begin
      usr_sw[0] = ~usr_sw[0];
      next_cycle();
    end
    wait_idle();
    assert (score >= `QSIZE && score < 2 * `QSIZE) else begin
      stop_run($sformatf("mismatch score: got 0x%0h, expected 0x%0h to 0x%0h",
                         score, `QSIZE, 2 * `QSIZE - 1));
    end
    check_val("piece_col", piece_col, `SPAWN_COL);
    check_val("piece_row", piece_row, 0);
  endtask

  task automatic test_countdown();
    int waited;
    waited = 0;
    check_val("start", start, 1);
    while (count_down != 0) begin
      next_cycle();
      waited++;
      if (waited > `COUNT_SEC * `SEC_TICK + 1000) begin
        stop_run("timeout waiting for count_down to reach zero");
      end
    end
    next_cycle();
    check_val("count_down", count_down, 0);
    check_val("over", over, 1);
  endtask

  initial begin
    void'($urandom(32'h575d));
    error_count = 0;
    clk         = 1'b0;
    reset_n     = 1'b0;
    usr_btn     = 4'h0;
    usr_sw      = 4'h0;
    uart_rx     = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    reset_n = 1'b1;
    repeat (2) next_cycle();

    test_reset_state();
    test_moves();
    test_queueing();
    test_switches_buttons();
    test_locking();
    test_overflow();
    test_countdown();

    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/debouncer.sv
`default_nettype none

`include "tetris_defines.svh"

module debouncer (
  input  logic clk,
  input  logic reset_n,
  input  logic in,
  output logic out
);

  localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);

  logic [1:0]       in_sync;
  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      in_sync <= 2'b00;
      cnt     <= '0;
      out     <= 1'b0;
    end else begin
      in_sync <= {in_sync[0], in};
      if (in_sync[1] == out) begin
        cnt <= '0;
      end else if (cnt == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
        // Enough agreeing samples, take the new level
        cnt <= '0;
        out <= in_sync[1];
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/game_control.sv
`default_nettype none

`include "tetris_defines.svh"

module game_control (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic [3:0]             btn_level,
  input  logic [3:0]             sw,
  input  logic [7:0]             rx_byte,
  input  logic                   rx_valid,
  input  tetris_pkg::game_state_t game_state,
  input  logic [3:0]             score,
  output tetris_pkg::command_t   command,
  output logic                   start,
  output logic                   over,
  output logic [5:0]             count_down
);

  localparam int SEC_W  = $clog2(`SEC_TICK);
  localparam int DOWN_W = $clog2(`DOWN_TICK + 1) + 1;
  localparam int OVER_W = $clog2(`OVER_TICK + 1);
  localparam int QIDX_W = $clog2(`QSIZE);

  logic [3:0]           btn_prev;
  logic [3:0]           btn_press;
  logic [3:0]           sw_q;
  logic [3:0]           sw_prev;
  logic [3:0]           sw_change;
  logic                 any_press;
  logic                 during;
  logic [SEC_W-1:0]     sec_cnt;
  logic [DOWN_W-1:0]    down_cnt;
  logic [DOWN_W-1:0]    down_tick;
  logic                 grav_fire;
  logic [OVER_W-1:0]    over_cnt;
  logic                 over_done;
  logic [7:0]           p_rx_byte;
  logic [7:0]           pp_rx_byte;
  logic                 arrow_prefix;
  tetris_pkg::command_t next_cmd;

  tetris_pkg::command_t queue [`QSIZE];
  logic [QIDX_W:0]      q_cnt;
  logic [QIDX_W-1:0]    wr_idx;
  logic                 q_full;
  logic                 pop;
  logic                 push_ok;

  // Edge detect on buttons, any level change on switches
  always_ff @(posedge clk) begin
    btn_prev <= btn_level;
    sw_q     <= sw;
    sw_prev  <= sw_q;
  end

  assign btn_press = btn_level & ~btn_prev;
  assign sw_change = sw_q ^ sw_prev;
  assign any_press = rx_valid | (|btn_press) | (|sw_change);

  assign over   = start && (count_down == 6'd0 || game_state == tetris_pkg::END);
  assign during = start && !over;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      start <= 1'b0;
    end else if (push_ok && next_cmd == tetris_pkg::INIT) begin
      start <= 1'b1;
    end else if (push_ok && next_cmd == tetris_pkg::END_GAME) begin
      start <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n || !during) begin
      sec_cnt <= '0;
    end else if (sec_cnt == SEC_W'(`SEC_TICK - 1)) begin
      sec_cnt <= '0;
    end else begin
      sec_cnt <= sec_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n || !start) begin
      count_down <= 6'(`COUNT_SEC);
    end else if (during && sec_cnt == SEC_W'(`SEC_TICK - 1)) begin
      count_down <= count_down - 1'b1;
    end
  end

  // Gravity speeds up with score
  assign down_tick = DOWN_W'(`DOWN_TICK - score * `DOWN_STEP);
  assign grav_fire = down_cnt >= down_tick;

  always_ff @(posedge clk) begin
    if (!reset_n || !during) begin
      down_cnt <= '0;
    end else if (next_cmd == tetris_pkg::DOWN) begin
      down_cnt <= '0;
    end else if (!grav_fire) begin
      down_cnt <= down_cnt + 1'b1;
    end
  end

  // Input lockout once the round is over
  always_ff @(posedge clk) begin
    if (!reset_n || !over) begin
      over_cnt <= '0;
    end else if (!over_done) begin
      over_cnt <= over_cnt + 1'b1;
    end
  end

  assign over_done = over_cnt == OVER_W'(`OVER_TICK);

  // Two-byte history for ESC [ x
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      p_rx_byte  <= 8'h00;
      pp_rx_byte <= 8'h00;
    end else if (rx_valid) begin
      p_rx_byte  <= rx_byte;
      pp_rx_byte <= p_rx_byte;
    end
  end

  assign arrow_prefix = pp_rx_byte == 8'h1B && p_rx_byte == 8'h5B;

  // Later assignments take priority
  always_comb begin
    next_cmd = tetris_pkg::NONE;
    if (!during) begin
      if (any_press) begin
        if (!over) begin
          next_cmd = tetris_pkg::INIT;
        end else if (over_done) begin
          next_cmd = tetris_pkg::END_GAME;
        end
      end
    end else begin
      if (grav_fire) next_cmd = tetris_pkg::DOWN;
      if (btn_press[0]) next_cmd = tetris_pkg::RIGHT;
      if (btn_press[1]) next_cmd = tetris_pkg::DOWN;
      if (btn_press[2]) next_cmd = tetris_pkg::ROTATE;
      if (btn_press[3]) next_cmd = tetris_pkg::LEFT;
      if (sw_change[0]) next_cmd = tetris_pkg::DROP;
      if (sw_change[1]) next_cmd = tetris_pkg::HOLD;
      if (sw_change[2]) next_cmd = tetris_pkg::ROTATE_REV;
      if (rx_valid) begin
        case (rx_byte)
          "A", "a":      next_cmd = tetris_pkg::LEFT;
          "D", "d":      next_cmd = tetris_pkg::RIGHT;
          "S", "s":      next_cmd = tetris_pkg::DOWN;
          "W", "w", " ": next_cmd = tetris_pkg::DROP;
          "C", "c":      next_cmd = tetris_pkg::HOLD;
          "X", "x":      next_cmd = tetris_pkg::ROTATE;
          "Z", "z":      next_cmd = tetris_pkg::ROTATE_REV;
          default: ;
        endcase
        if (arrow_prefix) begin
          case (rx_byte)
            8'h41:   next_cmd = tetris_pkg::ROTATE;
            8'h42:   next_cmd = tetris_pkg::DOWN;
            8'h43:   next_cmd = tetris_pkg::RIGHT;
            8'h44:   next_cmd = tetris_pkg::LEFT;
            default: ;
          endcase
        end
      end
    end
  end

  // Shift-register FIFO, head at slot 0, unused slots hold NONE
  assign command = queue[0];
  assign pop     = game_state != tetris_pkg::BUSY && queue[0] != tetris_pkg::NONE;
  assign q_full  = q_cnt == (QIDX_W + 1)'(`QSIZE);
  assign push_ok = next_cmd != tetris_pkg::NONE && (pop || !q_full);
  assign wr_idx  = pop ? QIDX_W'(q_cnt - 1'b1) : QIDX_W'(q_cnt);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      q_cnt <= '0;
      for (int i = 0; i < `QSIZE; i++) begin
        queue[i] <= tetris_pkg::NONE;
      end
    end else begin
      if (pop) begin
        for (int i = 0; i < `QSIZE - 1; i++) begin
          queue[i] <= queue[i+1];
        end
        queue[`QSIZE-1] <= tetris_pkg::NONE;
      end
      if (push_ok) begin
        queue[wr_idx] <= next_cmd;
      end
      if (push_ok && !pop) begin
        q_cnt <= q_cnt + 1'b1;
      end else if (pop && !push_ok) begin
        q_cnt <= q_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/piece_engine.sv
`default_nettype none

`include "tetris_defines.svh"

module piece_engine (
  input  logic                    clk,
  input  logic                    reset_n,
  input  tetris_pkg::command_t    command,
  output tetris_pkg::game_state_t game_state,
  output logic [3:0]              piece_col,
  output logic [4:0]              piece_row,
  output logic [1:0]              piece_rot,
  output logic                    held,
  output logic [3:0]              score
);

  localparam int BUSY_W = $clog2(`MOVE_CYCLES + 1);

  logic              accept;
  logic [BUSY_W-1:0] busy_cnt;
  logic              end_pending;

  // Anything but NONE is consumed outside BUSY
  assign accept = game_state != tetris_pkg::BUSY && command != tetris_pkg::NONE;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      game_state  <= tetris_pkg::IDLE;
      busy_cnt    <= '0;
      end_pending <= 1'b0;
      piece_col   <= 4'(`SPAWN_COL);
      piece_row   <= '0;
      piece_rot   <= '0;
      held        <= 1'b0;
      score       <= '0;
    end else if (game_state == tetris_pkg::BUSY) begin
      if (busy_cnt == '0) begin
        game_state <= end_pending ? tetris_pkg::END : tetris_pkg::WAIT;
      end else begin
        busy_cnt <= busy_cnt - 1'b1;
      end
    end else if (accept) begin
      if (command == tetris_pkg::END_GAME) begin
        game_state  <= tetris_pkg::IDLE;
        end_pending <= 1'b0;
      end else if (game_state == tetris_pkg::IDLE && command == tetris_pkg::INIT) begin
        game_state  <= tetris_pkg::BUSY;
        busy_cnt    <= BUSY_W'(`MOVE_CYCLES - 1);
        end_pending <= 1'b0;
        piece_col   <= 4'(`SPAWN_COL);
        piece_row   <= '0;
        piece_rot   <= '0;
        held        <= 1'b0;
        score       <= '0;
      end else if (game_state == tetris_pkg::WAIT && command != tetris_pkg::INIT) begin
        game_state <= tetris_pkg::BUSY;
        busy_cnt   <= BUSY_W'(`MOVE_CYCLES - 1);
        case (command)
          tetris_pkg::LEFT: begin
            if (piece_col != 4'd0) begin
              piece_col <= piece_col - 1'b1;
            end
          end
          tetris_pkg::RIGHT: begin
            if (piece_col != 4'(`BOARD_COLS - 1)) begin
              piece_col <= piece_col + 1'b1;
            end
          end
          tetris_pkg::ROTATE:     piece_rot <= piece_rot + 1'b1;
          tetris_pkg::ROTATE_REV: piece_rot <= piece_rot - 1'b1;
          tetris_pkg::HOLD: begin
            held      <= ~held;
            piece_col <= 4'(`SPAWN_COL);
            piece_row <= '0;
            piece_rot <= '0;
          end
          tetris_pkg::DOWN, tetris_pkg::DROP: begin
            if (command == tetris_pkg::DOWN && piece_row != 5'(`BOARD_ROWS - 1)) begin
              piece_row <= piece_row + 1'b1;
            end else begin
              // Lock and spawn the next piece
              score     <= score + 1'b1;
              piece_col <= 4'(`SPAWN_COL);
              piece_row <= '0;
              piece_rot <= '0;
              if (score == 4'(`MAX_PIECES - 1)) begin
                end_pending <= 1'b1;
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/tetris_defines.svh
`ifndef TETRIS_DEFINES_SVH
`define TETRIS_DEFINES_SVH

// UART bit time in clocks
`define CLKS_PER_BIT 16

// Stable samples before a button level changes
`define DEBOUNCE_CYCLES 8

// Round timing
`define SEC_TICK 200
`define COUNT_SEC 60
`define DOWN_TICK 4000
`define DOWN_STEP 200
`define OVER_TICK 50

// Command queue and engine timing
`define QSIZE 4
`define MOVE_CYCLES 3

// Board geometry
`define BOARD_COLS 10
`define BOARD_ROWS 20
`define SPAWN_COL 4
`define MAX_PIECES 8

`endif

// File: logic/tetris_input_top.sv
`default_nettype none

module tetris_input_top (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic [3:0]              usr_btn,
  input  logic [3:0]              usr_sw,
  input  logic                    uart_rx,
  output logic                    start,
  output logic                    over,
  output logic [5:0]              count_down,
  output tetris_pkg::game_state_t game_state,
  output logic [3:0]              piece_col,
  output logic [4:0]              piece_row,
  output logic [1:0]              piece_rot,
  output logic                    held,
  output logic [3:0]              score
);

  logic [7:0]           rx_byte;
  logic                 rx_valid;
  logic [3:0]           btn_level;
  tetris_pkg::command_t command;

  uart_rx u_rx (
    .clk     (clk),
    .reset_n (reset_n),
    .rx      (uart_rx),
    .rx_byte (rx_byte),
    .rx_valid(rx_valid)
  );

  for (genvar gi = 0; gi < 4; gi++) begin : g_btn
    debouncer u_debouncer (
      .clk    (clk),
      .reset_n(reset_n),
      .in     (usr_btn[gi]),
      .out    (btn_level[gi])
    );
  end

  game_control u_control (
    .clk       (clk),
    .reset_n   (reset_n),
    .btn_level (btn_level),
    .sw        (usr_sw),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .game_state(game_state),
    .score     (score),
    .command   (command),
    .start     (start),
    .over      (over),
    .count_down(count_down)
  );

  piece_engine u_engine (
    .clk       (clk),
    .reset_n   (reset_n),
    .command   (command),
    .game_state(game_state),
    .piece_col (piece_col),
    .piece_row (piece_row),
    .piece_rot (piece_rot),
    .held      (held),
    .score     (score)
  );

endmodule

`default_nettype wire

// File: logic/tetris_pkg.sv
`default_nettype none

package tetris_pkg;

  // Engine state as seen by the controller
  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    BUSY,
    END
  } game_state_t;

  // Commands carried from the controller queue to the engine
  typedef enum logic [3:0] {
    NONE,
    INIT,
    END_GAME,
    LEFT,
    RIGHT,
    DOWN,
    ROTATE,
    ROTATE_REV,
    DROP,
    HOLD
  } command_t;

endpackage

`default_nettype wire

// File: logic/uart_rx.sv
`default_nettype none

`include "tetris_defines.svh"

module uart_rx (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  localparam int CNT_W = $clog2(`CLKS_PER_BIT);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic [1:0]       rx_sync;
  logic             rx_s;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;

  // Line idles high
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], rx};
    end
  end

  assign rx_s = rx_sync[1];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (!rx_s) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // Recheck at mid start bit to reject glitches
          if (clk_cnt == CNT_W'(`CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt == CNT_W'(`CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            shift   <= {rx_s, shift[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (clk_cnt == CNT_W'(`CLKS_PER_BIT - 1)) begin
            state <= RX_IDLE;
            // Framing error drops the byte
            if (rx_s) begin
              rx_byte  <= shift;
              rx_valid <= 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tetris_input_top.f
+incdir+logic
logic/tetris_pkg.sv
logic/uart_rx.sv
logic/debouncer.sv
logic/game_control.sv
logic/piece_engine.sv
logic/tetris_input_top.sv
dv/tb_tetris_input.sv
